/* Bender.yml */
package:
  name: bram_fifo_core

sources:
  - files:
      - design/fifo_core_pkg.sv
      - design/fifo_level_if.sv
      - design/fifo_cfg_regs.sv
      - design/fifo_word_store.sv
      - design/fifo_status_readout.sv
      - design/bram_fifo_core.sv
  - target: test
    files:
      - test/bram_fifo_core_props.sv
      - test/tb_bram_fifo_core.sv

/* design/bram_fifo_core.sv */
// single clock on BUS_CLK, no handshake beyond plain strobes, upstream pulled while not full
`timescale 1ns/1ns
`default_nettype none

module bram_fifo_core import fifo_core_pkg::*; (
    input  logic        BUS_CLK,
    input  logic        RST,
    input  logic [15:0] BUS_ADD,
    input  logic [7:0]  BUS_DATA_IN,
    input  logic        BUS_RD,
    input  logic        BUS_WR,
    output logic [7:0]  BUS_DATA_OUT,

    input  logic        BUS_RD_DATA,
    input  logic        BUS_WR_DATA,
    input  word_t       BUS_DATA_IN_DATA,
    output word_t       BUS_DATA_OUT_DATA,

    output logic        FIFO_READ_NEXT_OUT,
    input  logic        FIFO_EMPTY_IN,
    input  word_t       FIFO_DATA,

    output logic        FIFO_NOT_EMPTY,
    output logic        FIFO_FULL,
    output logic        FIFO_NEAR_FULL,
    output logic        FIFO_READ_ERROR
);

    logic       core_rst;  // hard or soft reset
    logic [7:0] almost_full_val;
    logic [7:0] almost_empty_val;
    word_t      head_word;

    fifo_level_if lvl_if ();

    fifo_cfg_regs u_cfg_regs (
        .BUS_CLK         (BUS_CLK),
        .BUS_RST         (RST),
        .BUS_ADD         (BUS_ADD),
        .BUS_DATA_IN     (BUS_DATA_IN),
        .BUS_WR          (BUS_WR),
        .core_rst        (core_rst),
        .almost_full_val (almost_full_val),
        .almost_empty_val(almost_empty_val)
    );

    fifo_word_store u_word_store (
        .BUS_CLK       (BUS_CLK),
        .core_rst      (core_rst),
        .wr_bus        (BUS_WR_DATA),
        .wr_bus_data   (BUS_DATA_IN_DATA),
        .upstream_empty(FIFO_EMPTY_IN),
        .upstream_data (FIFO_DATA),
        .rd            (BUS_RD_DATA),
        .head_word     (head_word),
        .lvl           (lvl_if.store)
    );

    fifo_status_readout u_status_readout (
        .BUS_CLK         (BUS_CLK),
        .core_rst        (core_rst),
        .BUS_ADD         (BUS_ADD),
        .BUS_RD          (BUS_RD),
        .rd_data         (BUS_RD_DATA),
        .head_word       (head_word),
        .almost_full_val (almost_full_val),
        .almost_empty_val(almost_empty_val),
        .lvl             (lvl_if.monitor),
        .reg_rdata       (BUS_DATA_OUT),
        .data_out        (BUS_DATA_OUT_DATA),
        .near_full       (FIFO_NEAR_FULL),
        .read_error      (FIFO_READ_ERROR)
    );

    assign FIFO_READ_NEXT_OUT = !lvl_if.full;  // back-pressure to upstream
    assign FIFO_NOT_EMPTY = !lvl_if.empty;
    assign FIFO_FULL = lvl_if.full;

endmodule

`default_nettype wire

/* design/fifo_cfg_regs.sv */
// only addresses 0..7 are decoded, upper address bits must be zero; core_rst is combinational
`timescale 1ns/1ns
`default_nettype none

module fifo_cfg_regs import fifo_core_pkg::*; (
    input  logic        BUS_CLK,
    input  logic        BUS_RST,
    input  logic [15:0] BUS_ADD,
    input  logic [7:0]  BUS_DATA_IN,
    input  logic        BUS_WR,
    output logic        core_rst,
    output logic [7:0]  almost_full_val,
    output logic [7:0]  almost_empty_val
);

    logic      wr_hit;
    reg_addr_e wr_addr;

    // map occupies the low 8 addresses only
    assign wr_hit = BUS_WR && (BUS_ADD[15:3] == '0);
    assign wr_addr = reg_addr_e'(BUS_ADD[2:0]);

    // any write to the control slot resets the core, data byte ignored
    assign core_rst = BUS_RST | (wr_hit && (wr_addr == addr_ctrl));

    always_ff @(posedge BUS_CLK) begin
        if (core_rst) begin
            almost_full_val <= almost_full_default;
            almost_empty_val <= almost_empty_default;
        end else if (wr_hit) begin
            case (wr_addr)
                addr_almost_full: begin
                    almost_full_val <= BUS_DATA_IN;
                end
                addr_almost_empty: begin
                    almost_empty_val <= BUS_DATA_IN;
                end
                default: begin
                    // read-only slots, writes have no effect
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/fifo_core_pkg.sv */
// depth is fixed at 16 words (power of two, pointers wrap), thresholds scale in 1/256 of depth
`default_nettype none

package fifo_core_pkg;

    localparam int fifo_depth = 16;
    localparam int ptr_width = $clog2(fifo_depth);
    localparam int level_width = ptr_width + 1;   // 0 .. fifo_depth
    localparam int word_width = 32;

    // room for (threshold + 1) * depth before the >> 8
    localparam int thr_width = 8 + ptr_width + 1;

    // thresholds in percent of the 8-bit full scale
    localparam int almost_full_pct = 95;
    localparam int almost_empty_pct = 5;
    localparam logic [7:0] almost_full_default = 8'(255 * almost_full_pct / 100);
    localparam logic [7:0] almost_empty_default = 8'(255 * almost_empty_pct / 100);

    localparam logic [7:0] core_version = 8'd2;

    // register map, 8 byte-wide slots
    typedef enum logic [2:0] {
        addr_ctrl         = 3'd0,  // read: version, write: soft reset
        addr_almost_full  = 3'd1,
        addr_almost_empty = 3'd2,
        addr_read_err     = 3'd3,
        addr_size_b0      = 3'd4,  // reading this one latches the upper bytes
        addr_size_b1      = 3'd5,
        addr_size_b2      = 3'd6,
        addr_size_b3      = 3'd7
    } reg_addr_e;

    typedef logic [word_width-1:0] word_t;

endpackage

`default_nettype wire

/* design/fifo_level_if.sv */
// level and flags of the word store, single clock domain, driven only by the store
`timescale 1ns/1ns
`default_nettype none

interface fifo_level_if import fifo_core_pkg::*; ();

    logic [level_width-1:0] level;  // fill count in words
    logic                   empty;
    logic                   full;
    logic                   underrun;  // pop attempted while empty

    modport store (
        output level,
        output empty,
        output full,
        output underrun
    );

    modport monitor (
        input level,
        input empty,
        input full,
        input underrun
    );

endinterface

`default_nettype wire

/* design/fifo_status_readout.sv */
// register reads return data one cycle after BUS_RD; upper size bytes come from the addr 4 latch
`timescale 1ns/1ns
`default_nettype none

module fifo_status_readout import fifo_core_pkg::*; (
    input  logic          BUS_CLK,
    input  logic          core_rst,
    input  logic [15:0]   BUS_ADD,
    input  logic          BUS_RD,
    input  logic          rd_data,
    input  word_t         head_word,
    input  logic [7:0]    almost_full_val,
    input  logic [7:0]    almost_empty_val,
    fifo_level_if.monitor lvl,
    output logic [7:0]    reg_rdata,
    output word_t         data_out,
    output logic          near_full,
    output logic          read_error
);

    logic [thr_width-1:0] level_ext;
    logic [thr_width-1:0] nf_set_lvl;
    logic [thr_width-1:0] nf_clr_lvl;
    logic [7:0]           err_cnt;
    logic [31:0]          size_bytes;
    logic [31:8]          size_hi_buf;  // latched upper bytes
    logic                 addr_ok;
    reg_addr_e            rd_addr;

    // thresholds converted to word counts
    assign level_ext = thr_width'(lvl.level);
    assign nf_set_lvl = ((thr_width'(almost_full_val) + 1'b1) * thr_width'(fifo_depth)) >> 8;
    assign nf_clr_lvl = ((thr_width'(almost_empty_val) + 1'b1) * thr_width'(fifo_depth)) >> 8;

    // near full with hysteresis, set wins over clear
    always_ff @(posedge BUS_CLK) begin
        if (core_rst) begin
            near_full <= 1'b0;
        end else if ((level_ext >= nf_set_lvl) || (almost_full_val == '0)) begin
            near_full <= 1'b1;
        end else if ((lvl.level == '0) ||
                     ((almost_empty_val != '0) && (level_ext <= nf_clr_lvl))) begin
            near_full <= 1'b0;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (core_rst) begin
            err_cnt <= '0;
        end else if (lvl.underrun && (err_cnt != 8'hff)) begin
            err_cnt <= err_cnt + 1'b1;  // saturates at 255
        end
    end

    assign read_error = (err_cnt != '0);

    assign size_bytes = {{(32 - level_width - 2){1'b0}}, lvl.level, 2'b00};  // words * 4

    assign addr_ok = (BUS_ADD[15:3] == '0);
    assign rd_addr = reg_addr_e'(BUS_ADD[2:0]);

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RD && addr_ok && (rd_addr == addr_size_b0)) begin
            size_hi_buf <= size_bytes[31:8];
        end
    end

    // readback holds until the next read
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RD) begin
            if (!addr_ok) begin
                reg_rdata <= '0;
            end else begin
                case (rd_addr)
                    addr_ctrl:         reg_rdata <= core_version;
                    addr_almost_full:  reg_rdata <= almost_full_val;
                    addr_almost_empty: reg_rdata <= almost_empty_val;
                    addr_read_err:     reg_rdata <= err_cnt;
                    addr_size_b0:      reg_rdata <= size_bytes[7:0];
                    addr_size_b1:      reg_rdata <= size_hi_buf[15:8];
                    addr_size_b2:      reg_rdata <= size_hi_buf[23:16];
                    addr_size_b3:      reg_rdata <= size_hi_buf[31:24];
                    default:           reg_rdata <= '0;
                endcase
            end
        end
    end

    // popped word, empty pops leave the port unchanged
    always_ff @(posedge BUS_CLK) begin
        if (rd_data && !lvl.empty) begin
            data_out <= head_word;
        end
    end

endmodule

`default_nettype wire

/* design/fifo_word_store.sv */
// 16-word circular buffer, bus word beats upstream word, writes while full are dropped
`timescale 1ns/1ns
`default_nettype none

module fifo_word_store import fifo_core_pkg::*; (
    input  logic        BUS_CLK,
    input  logic        core_rst,
    input  logic        wr_bus,
    input  word_t       wr_bus_data,
    input  logic        upstream_empty,
    input  word_t       upstream_data,
    input  logic        rd,
    output word_t       head_word,
    fifo_level_if.store lvl
);

    word_t                  mem [fifo_depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [level_width-1:0] count;
    logic                   push_req;
    logic                   push;
    logic                   pop;
    word_t                  push_data;

    // upstream is pulled whenever it has data
    assign push_req = wr_bus | ~upstream_empty;
    assign push_data = wr_bus ? wr_bus_data : upstream_data;  // bus has priority

    assign push = push_req & ~lvl.full;
    assign pop = rd & ~lvl.empty;

    // flags follow the counter directly
    assign lvl.level = count;
    assign lvl.empty = (count == '0);
    assign lvl.full = (count == level_width'(fifo_depth));
    assign lvl.underrun = rd & lvl.empty;  // high for every empty pop cycle

    assign head_word = mem[rd_ptr];

    always_ff @(posedge BUS_CLK) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (core_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    // idle or push with pop, level unchanged
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* flist.f */
design/fifo_core_pkg.sv
design/fifo_level_if.sv
design/fifo_cfg_regs.sv
design/fifo_word_store.sv
design/fifo_status_readout.sv
design/bram_fifo_core.sv
test/bram_fifo_core_props.sv
test/tb_bram_fifo_core.sv

/* test/bram_fifo_core_props.sv */
// bound into bram_fifo_core, port-level invariants on BUS_CLK, failures counted in fail_cnt
`timescale 1ns/1ns
`default_nettype none

module bram_fifo_core_props (
    input logic BUS_CLK,
    input logic RST,
    input logic FIFO_READ_NEXT_OUT,
    input logic FIFO_FULL,
    input logic FIFO_NOT_EMPTY,
    input logic FIFO_READ_ERROR
);

    int unsigned fail_cnt = 0;

    // upstream pulled exactly while there is room
    a_next_out: assert property (@(posedge BUS_CLK) disable iff (RST)
        FIFO_READ_NEXT_OUT == !FIFO_FULL)
        else begin
            fail_cnt++;
            $error("upstream read strobe does not follow the full flag");
        end

    a_full_empty: assert property (@(posedge BUS_CLK) disable iff (RST)
        !(FIFO_FULL && !FIFO_NOT_EMPTY))
        else begin
            fail_cnt++;
            $error("full and empty flags both high");
        end

    a_err_reset: assert property (@(posedge BUS_CLK) RST |=> !FIFO_READ_ERROR)
        else begin
            fail_cnt++;
            $error("read error flag high right after reset");
        end

endmodule

bind bram_fifo_core bram_fifo_core_props u_props (.*);

`default_nettype wire

/* test/tb_bram_fifo_core.sv */
// inputs driven on the rising edge, outputs compared on the falling edge against a queue model
`timescale 1ns/1ns
`default_nettype none

module tb_bram_fifo_core import fifo_core_pkg::*; ();

    localparam int max_cycles = 4000;  // the full sequence runs well under 1000

    logic        BUS_CLK;
    logic        RST;
    logic [15:0] BUS_ADD;
    logic [7:0]  BUS_DATA_IN;
    logic        BUS_RD;
    logic        BUS_WR;
    logic [7:0]  BUS_DATA_OUT;
    logic        BUS_RD_DATA;
    logic        BUS_WR_DATA;
    word_t       BUS_DATA_IN_DATA;
    word_t       BUS_DATA_OUT_DATA;
    logic        FIFO_READ_NEXT_OUT;
    logic        FIFO_EMPTY_IN;
    word_t       FIFO_DATA;
    logic        FIFO_NOT_EMPTY;
    logic        FIFO_FULL;
    logic        FIFO_NEAR_FULL;
    logic        FIFO_READ_ERROR;

    // reference model state
    word_t       ref_q[$];
    int unsigned ref_err;
    logic [7:0]  ref_af;
    logic [7:0]  ref_ae;
    logic [23:0] ref_size_hi;
    logic        ref_nf;
    word_t       exp_data;
    logic [7:0]  exp_rdata;
    logic        chk_data = 1'b0;
    logic        chk_rd = 1'b0;
    logic        armed = 1'b0;
    int unsigned checks = 0;
    int unsigned errors = 0;
    int unsigned cycle_cnt = 0;

    bram_fifo_core u_dut (.*);

    initial begin
        BUS_CLK = 1'b0;
        forever #4 BUS_CLK = ~BUS_CLK;
    end

    always @(posedge BUS_CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout, sequence still running after %0d cycles", max_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // set at or above the upper mark, clear at empty or at or below the lower mark
    function automatic logic near_full_ref(logic cur, int level, logic [7:0] af, logic [7:0] ae);
        int set_lvl;
        int clr_lvl;
        set_lvl = (int'(af) + 1) * fifo_depth / 256;
        clr_lvl = (int'(ae) + 1) * fifo_depth / 256;
        if (level >= set_lvl || af == 8'd0) begin
            return 1'b1;
        end
        if (level == 0 || (ae != 8'd0 && level <= clr_lvl)) begin
            return 1'b0;
        end
        return cur;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic reg_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD <= addr;
        BUS_DATA_IN <= data;
        BUS_WR <= 1'b1;
        @(posedge BUS_CLK);
        BUS_WR <= 1'b0;
    endtask

    task automatic reg_read(input logic [15:0] addr);
        @(posedge BUS_CLK);
        BUS_ADD <= addr;
        BUS_RD <= 1'b1;
        @(posedge BUS_CLK);
        BUS_RD <= 1'b0;
    endtask

    task automatic push_word(input word_t w, input logic with_pop = 1'b0);
        @(posedge BUS_CLK);
        BUS_DATA_IN_DATA <= w;
        BUS_WR_DATA <= 1'b1;
        BUS_RD_DATA <= with_pop;
        @(posedge BUS_CLK);
        BUS_WR_DATA <= 1'b0;
        BUS_RD_DATA <= 1'b0;
    endtask

    task automatic pop_word();
        @(posedge BUS_CLK);
        BUS_RD_DATA <= 1'b1;
        @(posedge BUS_CLK);
        BUS_RD_DATA <= 1'b0;
    endtask

    task automatic drain_all(output int n);
        n = 0;
        @(negedge BUS_CLK);
        while (FIFO_NOT_EMPTY) begin
            pop_word();
            n++;
            @(negedge BUS_CLK);
        end
    endtask

    // new upstream word after each edge that took the current one
    task automatic fill_from_upstream();
        @(posedge BUS_CLK);
        FIFO_EMPTY_IN <= 1'b0;
        FIFO_DATA <= $urandom();
        @(negedge BUS_CLK);
        while (!FIFO_FULL) begin
            @(posedge BUS_CLK);
            FIFO_DATA <= $urandom();
            @(negedge BUS_CLK);
        end
    endtask

    // model sees the inputs the DUT samples at this edge
    always @(posedge BUS_CLK) begin : ref_model
        int lvl;
        logic push_ok;
        lvl = ref_q.size();
        armed = 1'b1;
        chk_rd = BUS_RD;
        chk_data = BUS_RD_DATA && lvl > 0;
        if (chk_data) begin
            exp_data = ref_q[0];
        end
        if (BUS_RD) begin
            case (BUS_ADD)
                16'd0: exp_rdata = core_version;
                16'd1: exp_rdata = ref_af;
                16'd2: exp_rdata = ref_ae;
                16'd3: exp_rdata = 8'(ref_err);
                16'd4: begin
                    exp_rdata = 8'(lvl * 4);
                    ref_size_hi = 24'((lvl * 4) >> 8);
                end
                16'd5: exp_rdata = ref_size_hi[7:0];
                16'd6: exp_rdata = ref_size_hi[15:8];
                16'd7: exp_rdata = ref_size_hi[23:16];
                default: exp_rdata = 8'h00;
            endcase
        end
        if (RST || (BUS_WR && BUS_ADD == 16'd0)) begin
            ref_q.delete();
            ref_err = 0;
            ref_af = almost_full_default;
            ref_ae = almost_empty_default;
            ref_nf = 1'b0;
        end else begin
            ref_nf = near_full_ref(ref_nf, lvl, ref_af, ref_ae);  // old level and thresholds
            push_ok = (BUS_WR_DATA || !FIFO_EMPTY_IN) && lvl < fifo_depth;
            if (BUS_RD_DATA && lvl > 0) begin
                void'(ref_q.pop_front());
            end else if (BUS_RD_DATA && ref_err < 255) begin
                ref_err++;
            end
            if (push_ok) begin
                ref_q.push_back(BUS_WR_DATA ? BUS_DATA_IN_DATA : FIFO_DATA);
            end
            if (BUS_WR && BUS_ADD == 16'd1) begin
                ref_af = BUS_DATA_IN;
            end
            if (BUS_WR && BUS_ADD == 16'd2) begin
                ref_ae = BUS_DATA_IN;
            end
        end
    end

    always @(negedge BUS_CLK) begin
        if (armed) begin
            check_byte("FIFO_FULL", 8'(FIFO_FULL), 8'(ref_q.size() == fifo_depth));
            check_byte("FIFO_NOT_EMPTY", 8'(FIFO_NOT_EMPTY), 8'(ref_q.size() != 0));
            check_byte("FIFO_READ_NEXT_OUT", 8'(FIFO_READ_NEXT_OUT),
                       8'(ref_q.size() != fifo_depth));
            check_byte("FIFO_NEAR_FULL", 8'(FIFO_NEAR_FULL), 8'(ref_nf));
            check_byte("FIFO_READ_ERROR", 8'(FIFO_READ_ERROR), 8'(ref_err != 0));
            if (chk_rd) begin
                check_byte("BUS_DATA_OUT", BUS_DATA_OUT, exp_rdata);
            end
            if (chk_data) begin
                check_word("BUS_DATA_OUT_DATA", BUS_DATA_OUT_DATA, exp_data);
            end
        end
    end

    initial begin : main_seq
        int n;
        void'($urandom(66823));
        RST = 1'b1;
        BUS_ADD = '0;
        BUS_DATA_IN = '0;
        BUS_RD = 1'b0;
        BUS_WR = 1'b0;
        BUS_RD_DATA = 1'b0;
        BUS_WR_DATA = 1'b0;
        BUS_DATA_IN_DATA = '0;
        FIFO_EMPTY_IN = 1'b1;
        FIFO_DATA = '0;
        repeat (2) @(posedge BUS_CLK);
        RST <= 1'b0;

        // bus words in order, then push with pop at level 3
        repeat (4) push_word($urandom());
        pop_word();
        repeat (3) push_word($urandom(), 1'b1);
        drain_all(n);

        // upstream stream until full, words wait while full
        fill_from_upstream();
        repeat (4) @(posedge BUS_CLK);
        FIFO_EMPTY_IN <= 1'b1;
        drain_all(n);
        check_byte("drained words", 8'(n), 8'(fifo_depth));

        // byte count, upper bytes latched by the addr 4 read
        repeat (7) push_word($urandom());
        reg_read(16'd4);
        repeat (3) push_word($urandom());
        for (int a = 5; a < 8; a++) begin
            reg_read(16'(a));
        end
        drain_all(n);

        @(posedge BUS_CLK);
        BUS_RD_DATA <= 1'b1;  // 300 empty pops
        repeat (300) @(posedge BUS_CLK);
        BUS_RD_DATA <= 1'b0;
        reg_read(16'd3);

        // hysteresis marks at 8 and 4 words
        reg_write(16'd1, 8'd127);
        reg_write(16'd2, 8'd63);
        repeat (fifo_depth) push_word($urandom());
        drain_all(n);

        // soft reset
        repeat (3) push_word($urandom());
        reg_write(16'd0, 8'h5a);
        for (int a = 0; a < 4; a++) begin
            reg_read(16'(a));
        end
        repeat (4) @(posedge BUS_CLK);

        errors += u_dut.u_props.fail_cnt;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
